//--- verilog/exec_macros.svh
// sizes for the execution back end; NUM_FU and RS_DEPTH at least 2, NUM_CDB <= NUM_FU, MULT_LAT >= 1
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

////////////////////////////////////////
// datapath widths
////////////////////////////////////////

`define XLEN        64                      // operand and result width
`define TAG_W       6                       // physical destination tag
`define ROB_IDX_W   6                       // reorder buffer index

////////////////////////////////////////
// structure sizes
////////////////////////////////////////

`define NUM_FU      4                       // identical alu units
`define NUM_CDB     2                       // result broadcast buses
`define RS_DEPTH    8                       // reservation station slots
`define MULT_LAT    4                       // cycles from capture to result for ALU_MUL

// derived index widths, parenthesized so they can size a cast
`define FU_IDX_W    ($clog2(`NUM_FU))       // unit select
`define RS_IDX_W    ($clog2(`RS_DEPTH))     // station slot select

`endif

//--- verilog/exec_pkg.sv
// operation-side types; operands are already resolved values, no tags are tracked for sources
`default_nettype none

`include "exec_macros.svh"

package exec_pkg;

	////////////////////////////////////////
	// alu function select
	////////////////////////////////////////

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,     // opa + opb
		ALU_SUB = 3'd1,     // opa - opb
		ALU_AND = 3'd2,     // bitwise and
		ALU_OR  = 3'd3,     // bitwise or
		ALU_XOR = 3'd4,     // bitwise xor
		ALU_SLL = 3'd5,     // opa << opb[5:0]
		ALU_SRL = 3'd6,     // logical opa >> opb[5:0]
		ALU_MUL = 3'd7      // low XLEN bits of the product, multi-cycle
	} alu_func_t;

	////////////////////////////////////////
	// operation as it travels rs -> fu
	////////////////////////////////////////

	// 143 bits with the default widths
	typedef struct packed {
		logic [`TAG_W-1:0]     tag;       // physical dest, comes back on the cdb
		logic [`ROB_IDX_W-1:0] rob_idx;   // rob slot, also returned
		alu_func_t             func;      // what to compute
		logic [`XLEN-1:0]      opa;       // operand a value
		logic [`XLEN-1:0]      opb;       // operand b value
	} exec_op_t;

endpackage

`default_nettype wire

//--- verilog/cdb_pkg.sv
// result-side types; the broadcast carries no branch or thread information
`default_nettype none

`include "exec_macros.svh"

package cdb_pkg;

	// what a unit offers the arbiter, 76 bits
	typedef struct packed {
		logic [`TAG_W-1:0]     tag;       // dest tag of the finished op
		logic [`ROB_IDX_W-1:0] rob_idx;   // its rob slot
		logic [`XLEN-1:0]      value;     // computed result
	} fu_result_t;

	// one common data bus, 77 bits
	typedef struct packed {
		logic                  valid;     // broadcast this cycle
		logic [`TAG_W-1:0]     tag;       // matches waiting consumers
		logic [`ROB_IDX_W-1:0] rob_idx;   // marks the rob entry executed
		logic [`XLEN-1:0]      value;     // result data
	} cdb_bus_t;

endpackage

`default_nettype wire

//--- verilog/issue_station.sv
// reservation station; all operands ready on entry, picks by slot order so it is not age ordered
`timescale 1ns/10ps
`default_nettype none

`include "exec_macros.svh"

module issue_station
	import exec_pkg::*;
(
	input  wire                              clock,
	input  wire                              arst_n,
	input  wire  exec_op_t                   op_in,        // op to store
	input  wire                              op_valid,     // op_in is present
	input  wire  [`NUM_FU-1:0]               available,    // unit can take an op this edge
	output logic                             op_ready,     // at least one free slot
	output exec_op_t [`NUM_FU-1:0]           issue_op,     // op per unit
	output logic [`NUM_FU-1:0]               issue_valid   // issue_op[i] is captured this edge
);

	localparam int DEPTH  = `RS_DEPTH;
	localparam int SLOT_W = `RS_IDX_W;

	exec_op_t [DEPTH-1:0]  slot_op;          // stored ops, payload only
	logic [DEPTH-1:0]      slot_vld;         // slot occupied
	logic [DEPTH-1:0]      slot_taken;       // slot issued this cycle
	logic [DEPTH-1:0]      slot_fill;        // slot written this cycle
	logic [SLOT_W-1:0]     free_idx;         // lowest empty slot
	logic                  accept;           // handshake on the input
	logic                  unit_done;        // current unit already paired

	////////////////////////////////////////
	// input side
	////////////////////////////////////////

	assign op_ready = ~&slot_vld;            // full only when every slot is held
	assign accept   = op_valid & op_ready;

	// lowest free slot, scanning down so the last hit wins
	always_comb begin
		free_idx = '0;
		for (int s = DEPTH - 1; s >= 0; s--) begin
			if (!slot_vld[s])
				free_idx = SLOT_W'(s);
		end
	end

	assign slot_fill = accept ? (DEPTH'(1) << free_idx) : '0;   // one-hot write strobe

	////////////////////////////////////////
	// issue side
	////////////////////////////////////////

	// walk units low to high and hand each free one the lowest unclaimed slot
	always_comb begin
		slot_taken  = '0;
		issue_valid = '0;
		issue_op    = '0;
		unit_done   = 1'b0;
		for (int u = 0; u < `NUM_FU; u++) begin
			unit_done = ~available[u];   // busy units never get an op
			for (int s = 0; s < DEPTH; s++) begin
				if (!unit_done && slot_vld[s] && !slot_taken[s]) begin
					unit_done      = 1'b1;
					slot_taken[s]  = 1'b1;       // freed at this edge
					issue_valid[u] = 1'b1;
					issue_op[u]    = slot_op[s];
				end
			end
		end
	end

	////////////////////////////////////////
	// storage
	////////////////////////////////////////

	// issued slots drop and the new op lands in a slot that was empty, so no overlap
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			slot_vld <= '0;
		end else begin
			slot_vld <= (slot_vld & ~slot_taken) | slot_fill;
		end
	end

	always_ff @(posedge clock) begin
		if (accept)
			slot_op[free_idx] <= op_in;     // visible to the pick logic next cycle
	end

endmodule

`default_nettype wire

//--- verilog/func_unit.sv
// one alu unit, one op at a time; multiply result is held MULT_LAT cycles, then kept until grant
`timescale 1ns/10ps
`default_nettype none

`include "exec_macros.svh"

module func_unit
	import exec_pkg::*;
	import cdb_pkg::*;
(
	input  wire              clock,
	input  wire              arst_n,
	input  wire  exec_op_t   issue_op,       // op from the station
	input  wire              issue_valid,    // capture issue_op at this edge
	input  wire              grant,          // send-in success from the arbiter
	output logic             available,      // idle, may be issued to
	output fu_result_t       result,         // held stable while result_valid
	output logic             result_valid    // result waiting for a bus
);

	localparam int CNT_W = $clog2(`MULT_LAT + 1);

	typedef enum logic [1:0] {
		FU_IDLE,                 // empty
		FU_EXEC,                 // counting down
		FU_DONE                  // result offered to the cdb
	} fu_state_t;

	fu_state_t         state;
	logic [CNT_W-1:0]  cnt;              // cycles left before the result is written
	exec_op_t          op_q;             // captured op, payload only
	logic [`XLEN-1:0]  alu_out;          // combinational result of op_q
	logic              capture;          // station hands over an op
	logic              finish;           // last exec cycle

	assign available    = (state == FU_IDLE);
	assign result_valid = (state == FU_DONE);
	assign capture      = issue_valid & available;
	assign finish       = (state == FU_EXEC) && (cnt == '0);

	////////////////////////////////////////
	// alu
	////////////////////////////////////////

	always_comb begin
		unique case (op_q.func)
			ALU_ADD: alu_out = op_q.opa + op_q.opb;
			ALU_SUB: alu_out = op_q.opa - op_q.opb;
			ALU_AND: alu_out = op_q.opa & op_q.opb;
			ALU_OR:  alu_out = op_q.opa | op_q.opb;
			ALU_XOR: alu_out = op_q.opa ^ op_q.opb;
			ALU_SLL: alu_out = op_q.opa << op_q.opb[5:0];   // low 6 bits only
			ALU_SRL: alu_out = op_q.opa >> op_q.opb[5:0];
			ALU_MUL: alu_out = op_q.opa * op_q.opb;         // upper half dropped
		endcase
	end

	////////////////////////////////////////
	// control
	////////////////////////////////////////

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= FU_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				FU_IDLE: begin
					if (capture) begin
						state <= FU_EXEC;
						// 0 gives the result one edge after capture
						cnt   <= (issue_op.func == ALU_MUL) ? CNT_W'(`MULT_LAT - 1) : '0;
					end
				end
				FU_EXEC: begin
					if (finish)
						state <= FU_DONE;
					else
						cnt <= cnt - 1'b1;
				end
				FU_DONE: begin
					if (grant)
						state <= FU_IDLE;   // free again after the grant edge
				end
				default: state <= FU_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// payload
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (capture)
			op_q <= issue_op;
		if (finish) begin
			result.tag     <= op_q.tag;
			result.rob_idx <= op_q.rob_idx;
			result.value   <= alu_out;       // frozen until the unit is idle
		end
	end

endmodule

`default_nettype wire

//--- verilog/cdb_arbiter.sv
// cdb arbiter; grants at most NUM_CDB units per cycle, buses are registered and cannot stall
`timescale 1ns/10ps
`default_nettype none

`include "exec_macros.svh"

module cdb_arbiter
	import cdb_pkg::*;
(
	input  wire                               clock,
	input  wire                               arst_n,
	input  wire  fu_result_t [`NUM_FU-1:0]    result,         // offers from the units
	input  wire  [`NUM_FU-1:0]                result_valid,
	output logic [`NUM_FU-1:0]                grant,          // send-in success per unit
	output cdb_bus_t [`NUM_CDB-1:0]           cdb             // broadcast, one cycle after grant
);

	localparam int FU_W = `FU_IDX_W;

	logic [FU_W-1:0]                   ptr;         // first unit looked at
	logic [FU_W-1:0]                   ptr_nxt;
	logic [`NUM_CDB-1:0]               sel_vld;     // bus c gets a result
	logic [`NUM_CDB-1:0][FU_W-1:0]     sel_idx;     // which unit feeds bus c
	logic [`NUM_CDB-1:0]               bus_vld;     // registered valid
	fu_result_t [`NUM_CDB-1:0]         bus_pay;     // registered payload
	int unsigned                       cand;        // unit under test
	int unsigned                       n_sel;       // buses filled so far

	////////////////////////////////////////
	// rotating pick
	////////////////////////////////////////

	always_comb begin
		grant   = '0;
		sel_vld = '0;
		sel_idx = '0;
		ptr_nxt = ptr;                            // stays put when nothing is granted
		n_sel   = 0;
		cand    = 0;
		for (int i = 0; i < `NUM_FU; i++) begin
			cand = (int'(ptr) + i) % `NUM_FU;
			if (result_valid[cand] && n_sel < `NUM_CDB) begin
				grant[cand]    = 1'b1;
				sel_vld[n_sel] = 1'b1;            // buses fill in grant order
				sel_idx[n_sel] = FU_W'(cand);
				ptr_nxt        = FU_W'((cand + 1) % `NUM_FU);   // past the last winner
				n_sel          = n_sel + 1;
			end
		end
	end

	////////////////////////////////////////
	// bus registers
	////////////////////////////////////////

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			bus_vld <= '0;
			ptr     <= '0;
		end else begin
			bus_vld <= sel_vld;
			ptr     <= ptr_nxt;
		end
	end

	always_ff @(posedge clock) begin
		for (int c = 0; c < `NUM_CDB; c++) begin
			if (sel_vld[c])
				bus_pay[c] <= result[sel_idx[c]];   // unit drops it at the same edge
		end
	end

	always_comb begin
		for (int c = 0; c < `NUM_CDB; c++) begin
			cdb[c].valid   = bus_vld[c];
			cdb[c].tag     = bus_pay[c].tag;
			cdb[c].rob_idx = bus_pay[c].rob_idx;
			cdb[c].value   = bus_pay[c].value;
		end
	end

endmodule

`default_nettype wire

//--- verilog/exec_core.sv
// execution back end top; one op per cycle in, NUM_CDB results out, no back-pressure on the buses
`timescale 1ns/10ps
`default_nettype none

`include "exec_macros.svh"

module exec_core
	import exec_pkg::*;
	import cdb_pkg::*;
(
	input  wire                        clock,
	input  wire                        arst_n,
	input  wire  exec_op_t             op_in,       // resolved op
	input  wire                        op_valid,
	output logic                       op_ready,    // station has room
	output cdb_bus_t [`NUM_CDB-1:0]    cdb          // result broadcasts
);

	exec_op_t [`NUM_FU-1:0]      issue_op;        // rs -> fu
	logic [`NUM_FU-1:0]          issue_valid;
	logic [`NUM_FU-1:0]          available;       // fu -> rs
	fu_result_t [`NUM_FU-1:0]    result;          // fu -> cdb
	logic [`NUM_FU-1:0]          result_valid;
	logic [`NUM_FU-1:0]          grant;           // cdb -> fu

	////////////////////////////////////////
	// reservation station
	////////////////////////////////////////

	issue_station u_rs (
		.clock       (clock),
		.arst_n      (arst_n),
		.op_in       (op_in),
		.op_valid    (op_valid),
		.available   (available),
		.op_ready    (op_ready),
		.issue_op    (issue_op),
		.issue_valid (issue_valid)
	);

	////////////////////////////////////////
	// alu units
	////////////////////////////////////////

	for (genvar i = 0; i < `NUM_FU; i++) begin : g_fu
		func_unit u_fu (
			.clock        (clock),
			.arst_n       (arst_n),
			.issue_op     (issue_op[i]),
			.issue_valid  (issue_valid[i]),
			.grant        (grant[i]),
			.available    (available[i]),
			.result       (result[i]),
			.result_valid (result_valid[i])
		);
	end

	////////////////////////////////////////
	// common data bus
	////////////////////////////////////////

	cdb_arbiter u_cdb (
		.clock        (clock),
		.arst_n       (arst_n),
		.result       (result),
		.result_valid (result_valid),
		.grant        (grant),
		.cdb          (cdb)
	);

endmodule

`default_nettype wire

//--- bench/exec_core_props.sv
// arbiter handshake checks, bound into every cdb_arbiter; failures also counted in err_cnt
`timescale 1ns/10ps
`default_nettype none

`include "exec_macros.svh"

module exec_core_props
	import cdb_pkg::*;
(
	input  wire                            clock,
	input  wire                            arst_n,
	input  wire  fu_result_t [`NUM_FU-1:0] result,        // unit offers
	input  wire  [`NUM_FU-1:0]             result_valid,
	input  wire  [`NUM_FU-1:0]             grant          // send-in success
);

	int unsigned err_cnt = 0;                            // polled by the bench monitor

	////////////////////////////////////////
	// grant rules
	////////////////////////////////////////

	a_grant_max: assert property (@(posedge clock) disable iff (!arst_n)
		$countones(grant) <= `NUM_CDB)                   // never more winners than buses
		else begin
			err_cnt++;
			$error("arbiter raised more grants than there are result buses");
		end

	a_grant_valid: assert property (@(posedge clock) disable iff (!arst_n)
		(grant & ~result_valid) == '0)                   // no grant to an idle unit
		else begin
			err_cnt++;
			$error("arbiter granted a unit with no valid result");
		end

	// a stalled unit keeps offering the same result
	for (genvar i = 0; i < `NUM_FU; i++) begin : g_hold
		a_hold: assert property (@(posedge clock) disable iff (!arst_n)
			result_valid[i] && !grant[i] |=> result_valid[i] && $stable(result[i]))
			else begin
				err_cnt++;
				$error("unit %0d dropped or changed an ungranted result", i);
			end
	end

endmodule

bind cdb_arbiter exec_core_props u_props (
	.clock        (clock),
	.arst_n       (arst_n),
	.result       (result),
	.result_valid (result_valid),
	.grant        (grant)
);

`default_nettype wire

//--- bench/exec_core_tb.sv
// at most 2**TAG_W ops per run since tags are not reused; needs exec_core_props bound in
`timescale 1ns/10ps
`default_nettype none

`include "exec_macros.svh"

module exec_core_tb
	import exec_pkg::*;
	import cdb_pkg::*;
();

	localparam int NTAG      = 1 << `TAG_W;
	localparam int BURST_LEN = 28;                       // enough to fill the station
	localparam int NROWS     = 17;

	typedef struct packed {
		alu_func_t        func;
		logic             rnd;                           // operands from the lfsr
		logic             burst;                         // BURST_LEN back-to-back copies
		logic [`XLEN-1:0] opa;
		logic [`XLEN-1:0] opb;
	} stim_t;

	localparam stim_t STIM [NROWS] = '{
		'{ALU_ADD, 1'b0, 1'b0, 64'hffff_ffff_ffff_ffff, 64'h1},       // carry out lost
		'{ALU_SUB, 1'b0, 1'b0, 64'h5, 64'h7},                         // wraps negative
		'{ALU_AND, 1'b0, 1'b0, 64'hf0f0_f0f0_f0f0_f0f0, 64'h0ff0_0ff0_0ff0_0ff0},
		'{ALU_OR,  1'b0, 1'b0, 64'h1234_0000_0000_5678, 64'h0000_abcd_ef00_0000},
		'{ALU_XOR, 1'b0, 1'b0, 64'haaaa_aaaa_aaaa_aaaa, 64'hffff_0000_ffff_0000},
		'{ALU_SLL, 1'b0, 1'b0, 64'h1, 64'hffff_ffff_ffff_ff7f},       // amount 63
		'{ALU_SRL, 1'b0, 1'b0, 64'h8000_0000_0000_0000, 64'h44},      // amount 4
		'{ALU_MUL, 1'b0, 1'b0, 64'h1_0000_0001, 64'hffff_ffff_ffff_ffff},
		'{ALU_MUL, 1'b1, 1'b0, 64'h0, 64'h0},                         // mul first may finish last
		'{ALU_ADD, 1'b1, 1'b0, 64'h0, 64'h0},
		'{ALU_SRL, 1'b1, 1'b0, 64'h0, 64'h0},
		'{ALU_SUB, 1'b1, 1'b0, 64'h0, 64'h0},
		'{ALU_AND, 1'b1, 1'b0, 64'h0, 64'h0},
		'{ALU_OR,  1'b1, 1'b0, 64'h0, 64'h0},
		'{ALU_XOR, 1'b1, 1'b0, 64'h0, 64'h0},
		'{ALU_SLL, 1'b1, 1'b0, 64'h0, 64'h0},
		'{ALU_MUL, 1'b1, 1'b1, 64'h0, 64'h0}                          // back-to-back multiplies
	};

	logic                    clock;
	logic                    arst_n;
	exec_op_t                op_in;
	logic                    op_valid;
	logic                    op_ready;
	cdb_bus_t [`NUM_CDB-1:0] cdb;
	logic [31:0]             lfsr = 32'h3560;
	logic [`XLEN-1:0]        exp_val [NTAG];              // scoreboard indexed by tag
	logic [`ROB_IDX_W-1:0]   exp_rob [NTAG];
	string                   exp_name [NTAG];
	logic [NTAG-1:0]         pending;                     // accepted but not yet broadcast
	int                      n_sent;
	int                      n_seen;
	logic                    saw_full;                    // op_ready seen low

	exec_core dut (
		.clock    (clock),
		.arst_n   (arst_n),
		.op_in    (op_in),
		.op_valid (op_valid),
		.op_ready (op_ready),
		.cdb      (cdb)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	////////////////////////////////////////
	// reference model and helpers
	////////////////////////////////////////

	// taps 32 22 2 1 with one step per bit taken
	function automatic logic [`XLEN-1:0] lfsr_word();
		logic [`XLEN-1:0] w;
		logic             fb;
		w = '0;
		for (int b = 0; b < `XLEN; b++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			w    = {w[`XLEN-2:0], fb};
		end
		return w;
	endfunction

	function automatic logic [`XLEN-1:0] model_alu(alu_func_t f, logic [`XLEN-1:0] a,
	                                               logic [`XLEN-1:0] b);
		case (f)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR:  return a | b;
			ALU_XOR: return a ^ b;
			ALU_SLL: return a << b[5:0];                 // only 6 bits of shift amount
			ALU_SRL: return a >> b[5:0];
			default: return a * b;                       // low half of the product
		endcase
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [`XLEN-1:0] exp,
	                           input logic [`XLEN-1:0] act);
		if (act !== exp)
			stop_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
	endtask

	// waits out a full station then holds op_valid for exactly one accepting edge
	task automatic send_op(input int row, input alu_func_t f, input logic [`XLEN-1:0] a,
	                       input logic [`XLEN-1:0] b);
		logic [`TAG_W-1:0] tag;
		tag = `TAG_W'(n_sent);
		while (!op_ready) begin
			saw_full = 1'b1;
			@(posedge clock);
			#1;
		end
		op_in         = '{tag: tag, rob_idx: `ROB_IDX_W'(NTAG - 1 - n_sent),
		                  func: f, opa: a, opb: b};
		op_valid      = 1'b1;
		exp_val[tag]  = model_alu(f, a, b);
		exp_rob[tag]  = op_in.rob_idx;
		exp_name[tag] = $sformatf("row%0d_%s_tag%0d", row, f.name(), tag);
		pending[tag]  = 1'b1;
		n_sent++;
		@(posedge clock);
		#1;
		op_valid = 1'b0;
	endtask

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	initial begin
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
		op_in    = '0;
		op_valid = 1'b0;
		arst_n   = 1'b0;
		pending  = '0;
		n_sent   = 0;
		n_seen   = 0;
		saw_full = 1'b0;
		repeat (4) @(posedge clock);
		#1;
		arst_n = 1'b1;
		check_value("reset_op_ready", 1, op_ready);
		for (int c = 0; c < `NUM_CDB; c++)
			check_value($sformatf("reset_cdb%0d_valid", c), 0, cdb[c].valid);
		foreach (STIM[r]) begin
			for (int k = 0; k < (STIM[r].burst ? BURST_LEN : 1); k++) begin
				a = STIM[r].rnd ? lfsr_word() : STIM[r].opa;
				b = STIM[r].rnd ? lfsr_word() : STIM[r].opb;
				send_op(r, STIM[r].func, a, b);
			end
		end
		while (n_seen != n_sent)
			@(posedge clock);
		repeat (`MULT_LAT + 4) @(posedge clock);         // room for a late duplicate
		if (!saw_full)
			stop_run("op_ready never went low during the multiply burst");
		else begin
			$display("=== PASS ===");
			$finish;
		end
	end

	////////////////////////////////////////
	// cdb monitor sampled mid-cycle
	////////////////////////////////////////

	always @(negedge clock) begin
		logic [`TAG_W-1:0] t;
		if (arst_n) begin
			if (dut.u_cdb.u_props.err_cnt != 0)
				stop_run("an assertion on the cdb arbiter handshake failed");
			for (int c = 0; c < `NUM_CDB; c++) begin
				t = cdb[c].tag;
				for (int d = 0; d < c; d++) begin
					if (cdb[c].valid && cdb[d].valid && cdb[d].tag == t)
						stop_run($sformatf("tag %0d on two buses in one cycle", t));
				end
				if (cdb[c].valid && !pending[t])
					stop_run($sformatf("tag %0d broadcast but never accepted or already seen", t));
				else if (cdb[c].valid) begin
					check_value(exp_name[t], exp_val[t], cdb[c].value);
					check_value({exp_name[t], "_rob"}, exp_rob[t], cdb[c].rob_idx);
					pending[t] = 1'b0;
					n_seen++;
				end
			end
		end
	end

	// budget scales with the number of operations in the table
	initial begin
		int limit;
		limit = 50;
		foreach (STIM[r])
			limit += (STIM[r].burst ? BURST_LEN : 1) * (`MULT_LAT + `RS_DEPTH + 4);
		repeat (limit) @(posedge clock);
		stop_run($sformatf("timeout after %0d cycles with %0d of %0d results seen",
		                   limit, n_seen, n_sent));
	end

endmodule

`default_nettype wire

//--- exec_core.f
+incdir+verilog
verilog/exec_pkg.sv
verilog/cdb_pkg.sv
verilog/issue_station.sv
verilog/func_unit.sv
verilog/cdb_arbiter.sv
verilog/exec_core.sv
bench/exec_core_props.sv
bench/exec_core_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   ?= exec_core.f
TB_TOP     ?= exec_core_tb
RTL_TOP    ?= exec_core
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_MSG   ?= === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o $(TB_TOP)
	@out="$$(./$(OBJ_DIR)/$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
